// File: Makefile
TOP = tb_raycast_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) --Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: src/raycast_pkg.sv
`default_nettype none

package raycast_pkg;

  // Pixel colour as two bits per channel, blue in the top bits
  typedef logic [5:0] rgb_t;

  // Pixel column or line number
  typedef logic [9:0] pos_t;

  // Horizontal porch and sync widths, counted from the end of the visible width
  localparam int H_FRONT = 16;
  localparam int H_SYNC  = 96;

  // Vertical porch and sync heights, counted from the end of the visible height
  localparam int V_FRONT = 10;
  localparam int V_SYNC  = 2;

  // Register bank address space
  typedef logic [3:0] reg_addr_t;

  localparam reg_addr_t REG_SKY       = 4'd0;
  localparam reg_addr_t REG_FLOOR     = 4'd1;
  localparam reg_addr_t REG_WALL_HALF = 4'd2;
  localparam reg_addr_t REG_TEX_STEP  = 4'd3;
  localparam reg_addr_t REG_SLICE     = 4'd4;

  // One register frame is the address followed by the data, MSB first
  localparam int REG_FRAME_BITS = 16;

  // Texture step per wall pixel, 4 integer bits and 8 fraction bits
  typedef logic [11:0] tex_step_t;

  // Values the register bank holds after reset
  localparam rgb_t      SKY_RESET       = 6'h15;
  localparam rgb_t      FLOOR_RESET     = 6'h2A;
  localparam logic [8:0] WALL_HALF_RESET = 9'd0;
  localparam tex_step_t TEX_STEP_RESET  = 12'd256;
  localparam logic [8:0] SLICE_RESET     = 9'd0;

endpackage

`default_nettype wire

// File: src/raycast_top.sv
`timescale 1ns/1ps
`default_nettype none

module raycast_top
  import raycast_pkg::*, tex_flash_pkg::*;
#(
  parameter int H_VIEW  = 640,
  parameter int H_TOTAL = 800,
  parameter int V_VIEW  = 480,
  parameter int V_TOTAL = 525
) (
  input  logic       clk,
  input  logic       i_rst,
  input  logic       i_reg_ss_n,
  input  logic       i_reg_sclk,
  input  logic       i_reg_mosi,
  input  logic [3:0] i_tex_in,
  output logic       o_tex_csb,
  output logic       o_tex_sclk,
  output logic       o_tex_out0,
  output logic       o_tex_oeb0,
  output logic       o_hsync_n,
  output logic       o_vsync_n,
  output rgb_t       o_rgb,
  output logic       o_hblank,
  output logic       o_vblank,
  output pos_t       o_hpos,
  output pos_t       o_vpos
);

  logic        hsync;
  logic        vsync;
  logic        visible;
  logic        hmax;
  logic        frame_end;
  rgb_t        sky;
  rgb_t        floor_col;
  logic [8:0]  wall_half;
  tex_step_t   tex_step;
  slice_addr_t slice;
  texel_idx_t  texel_idx;
  texel_t      texel;

  vga_timing #(
    .H_VIEW  (H_VIEW),
    .H_TOTAL (H_TOTAL),
    .V_VIEW  (V_VIEW),
    .V_TOTAL (V_TOTAL)
  ) u_vga_timing (
    .clk         (clk),
    .i_rst       (i_rst),
    .o_hpos      (o_hpos),
    .o_vpos      (o_vpos),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_visible   (visible),
    .o_hmax      (hmax),
    .o_frame_end (frame_end)
  );

  // Monitor expects active low sync
  assign o_hsync_n = ~hsync;
  assign o_vsync_n = ~vsync;
  assign o_hblank  = ~(o_hpos < pos_t'(H_VIEW));
  assign o_vblank  = ~(o_vpos < pos_t'(V_VIEW));

  // Slice for the next line is fetched from flash at the tail of this one
  tex_flash_reader #(.H_VIEW(H_VIEW)) u_tex_flash_reader (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_hpos      (o_hpos),
    .i_slice     (slice),
    .i_tex_in    (i_tex_in),
    .i_texel_idx (texel_idx),
    .o_tex_csb   (o_tex_csb),
    .o_tex_sclk  (o_tex_sclk),
    .o_tex_out0  (o_tex_out0),
    .o_tex_oeb0  (o_tex_oeb0),
    .o_texel     (texel)
  );

  reg_spi_bank u_reg_spi_bank (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_ss_n      (i_reg_ss_n),
    .i_sclk      (i_reg_sclk),
    .i_mosi      (i_reg_mosi),
    .i_frame_end (frame_end),
    .o_sky       (sky),
    .o_floor     (floor_col),
    .o_wall_half (wall_half),
    .o_tex_step  (tex_step),
    .o_slice     (slice)
  );

  row_shader #(.H_VIEW(H_VIEW)) u_row_shader (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_hpos      (o_hpos),
    .i_visible   (visible),
    .i_hmax      (hmax),
    .i_sky       (sky),
    .i_floor     (floor_col),
    .i_wall_half (wall_half),
    .i_tex_step  (tex_step),
    .i_texel     (texel),
    .o_texel_idx (texel_idx),
    .o_rgb       (o_rgb)
  );

endmodule

`default_nettype wire

// File: src/reg_spi_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_spi_bank
  import raycast_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst,
  input  logic       i_ss_n,
  input  logic       i_sclk,
  input  logic       i_mosi,
  input  logic       i_frame_end,
  output rgb_t       o_sky,
  output rgb_t       o_floor,
  output logic [8:0] o_wall_half,
  output tex_step_t  o_tex_step,
  output logic [8:0] o_slice
);

  localparam int DATA_BITS = REG_FRAME_BITS - $bits(reg_addr_t);

  // Two stages of synchroniser, plus a third on the strobes for edge detection
  logic [2:0] sclk_sr;
  logic [2:0] ss_sr;
  logic [1:0] mosi_sr;
  logic       sclk_rise;
  logic       ss_rise;
  logic       ss_active;

  // Bit counter saturates so an overlong frame never wraps back to 16
  logic [4:0]                bit_cnt;
  logic [REG_FRAME_BITS-1:0] frame_sr;
  reg_addr_t                 frame_addr;
  logic [DATA_BITS-1:0]      frame_data;
  logic                      frame_ok;

  // Shadow copies that collect writes during the frame
  rgb_t       sky_sh;
  rgb_t       floor_sh;
  logic [8:0] wall_half_sh;
  tex_step_t  tex_step_sh;
  logic [8:0] slice_sh;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      sclk_sr <= '0;
      ss_sr   <= '1;
      mosi_sr <= '0;
    end else begin
      sclk_sr <= {sclk_sr[1:0], i_sclk};
      ss_sr   <= {ss_sr[1:0], i_ss_n};
      mosi_sr <= {mosi_sr[0], i_mosi};
    end
  end

  assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
  assign ss_rise   = ss_sr[1] & ~ss_sr[2];
  assign ss_active = ~ss_sr[1];

  // Count and shift while the master holds select low
  always_ff @(posedge clk) begin
    if (i_rst || !ss_active) begin
      bit_cnt <= '0;
    end else if (sclk_rise && (bit_cnt != 5'h1F)) begin
      bit_cnt <= bit_cnt + 5'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (ss_active && sclk_rise) begin
      frame_sr <= {frame_sr[REG_FRAME_BITS-2:0], mosi_sr[1]};
    end
  end

  assign frame_addr = frame_sr[REG_FRAME_BITS-1:DATA_BITS];
  assign frame_data = frame_sr[DATA_BITS-1:0];
  assign frame_ok   = ss_rise && (bit_cnt == 5'(REG_FRAME_BITS));

  // A complete frame updates one shadow; unknown addresses fall through
  always_ff @(posedge clk) begin
    if (i_rst) begin
      sky_sh       <= SKY_RESET;
      floor_sh     <= FLOOR_RESET;
      wall_half_sh <= WALL_HALF_RESET;
      tex_step_sh  <= TEX_STEP_RESET;
      slice_sh     <= SLICE_RESET;
    end else if (frame_ok) begin
      case (frame_addr)
        REG_SKY:       sky_sh       <= frame_data[5:0];
        REG_FLOOR:     floor_sh     <= frame_data[5:0];
        REG_WALL_HALF: wall_half_sh <= frame_data[8:0];
        REG_TEX_STEP:  tex_step_sh  <= frame_data;
        REG_SLICE:     slice_sh     <= frame_data[8:0];
        default:       ;
      endcase
    end
  end

  // Outputs only move at frame end, so a frame is never drawn with mixed values
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_sky       <= SKY_RESET;
      o_floor     <= FLOOR_RESET;
      o_wall_half <= WALL_HALF_RESET;
      o_tex_step  <= TEX_STEP_RESET;
      o_slice     <= SLICE_RESET;
    end else if (i_frame_end) begin
      o_sky       <= sky_sh;
      o_floor     <= floor_sh;
      o_wall_half <= wall_half_sh;
      o_tex_step  <= tex_step_sh;
      o_slice     <= slice_sh;
    end
  end

endmodule

`default_nettype wire

// File: src/row_shader.sv
`timescale 1ns/1ps
`default_nettype none

module row_shader
  import raycast_pkg::*, tex_flash_pkg::*;
#(
  parameter int H_VIEW = 640
) (
  input  logic       clk,
  input  logic       i_rst,
  input  pos_t       i_hpos,
  input  logic       i_visible,
  input  logic       i_hmax,
  input  rgb_t       i_sky,
  input  rgb_t       i_floor,
  input  logic [8:0] i_wall_half,
  input  tex_step_t  i_tex_step,
  input  texel_t     i_texel,
  output texel_idx_t o_texel_idx,
  output rgb_t       o_rgb
);

  // Screen midpoint, the centre of every wall span
  localparam int HALF = H_VIEW / 2;

  // Texture coordinate in 6.8 fixed point, wraps every 64 texels
  logic [13:0] tex_acc;
  logic [10:0] hpos_plus_half;
  logic [10:0] span_end;
  logic        in_wall;

  // Span test is rearranged so nothing goes negative when wall_half exceeds HALF
  assign hpos_plus_half = {1'b0, i_hpos} + {2'b00, i_wall_half};
  assign span_end       = 11'(HALF) + {2'b00, i_wall_half};

  assign in_wall = (hpos_plus_half >= 11'(HALF)) && ({1'b0, i_hpos} < span_end);

  // Line end restarts the texture at its top, each wall pixel then moves down
  // by one step
  always_ff @(posedge clk) begin
    if (i_rst || i_hmax) begin
      tex_acc <= '0;
    end else if (in_wall) begin
      tex_acc <= tex_acc + {2'b00, i_tex_step};
    end
  end

  // Integer part of the accumulator picks the texel
  assign o_texel_idx = tex_acc[13:8];

  // Black outside the view, then wall, then floor left and sky right
  always_comb begin
    if (!i_visible) begin
      o_rgb = '0;
    end else if (in_wall) begin
      o_rgb = i_texel;
    end else if (i_hpos < pos_t'(HALF)) begin
      o_rgb = i_floor;
    end else begin
      o_rgb = i_sky;
    end
  end

endmodule

`default_nettype wire

// File: src/tex_flash_pkg.sv
`default_nettype none

package tex_flash_pkg;

  // Quad output fast read, data comes back on all four IO lines
  localparam logic [7:0] FLASH_CMD = 8'h6B;

  // Preamble field lengths in flash clock cycles
  localparam int CMD_LEN   = 8;
  localparam int ADDR_LEN  = 24;
  localparam int DUMMY_LEN = 8;
  localparam int PREAMBLE_LEN = CMD_LEN + ADDR_LEN + DUMMY_LEN;

  // One wall slice is 64 texels of one byte each, so two nibbles per texel
  localparam int TEXEL_COUNT = 64;
  localparam int READ_LEN    = TEXEL_COUNT * 2;
  localparam int STREAM_LEN  = PREAMBLE_LEN + READ_LEN;

  // Slice number, sent as flash address bits 14 to 6
  typedef logic [8:0] slice_addr_t;

  // Texel position within a slice
  typedef logic [5:0] texel_idx_t;

  // Texel colour, packed the same way as a pixel colour
  typedef logic [5:0] texel_t;

endpackage

`default_nettype wire

// File: src/tex_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tex_flash_reader
  import raycast_pkg::*, tex_flash_pkg::*;
#(
  parameter int H_VIEW = 640
) (
  input  logic        clk,
  input  logic        i_rst,
  input  pos_t        i_hpos,
  input  slice_addr_t i_slice,
  input  logic [3:0]  i_tex_in,
  input  texel_idx_t  i_texel_idx,
  output logic        o_tex_csb,
  output logic        o_tex_sclk,
  output logic        o_tex_out0,
  output logic        o_tex_oeb0,
  output texel_t      o_texel
);

  // The stream ends its preamble exactly when the visible part of the line ends
  localparam pos_t READ_START = pos_t'(H_VIEW - PREAMBLE_LEN);

  // Slice bits land on flash address bits 14 to 6, one byte per texel
  localparam int   SLICE_FIRST = CMD_LEN + ADDR_LEN - $bits(slice_addr_t) - $clog2(TEXEL_COUNT);
  localparam int   SLICE_LAST  = SLICE_FIRST + $bits(slice_addr_t) - 1;
  localparam logic [2:0] CMD_MSB   = 3'(CMD_LEN - 1);
  localparam logic [3:0] SLICE_END = 4'(SLICE_LAST);

  // Stream state counts from the start of the read and wraps at 1024
  pos_t       tspi_state;
  logic       data_present;
  logic [2:0] cmd_sel;
  logic [3:0] slice_sel;

  // One 64-bit plane per colour bit, texel k at bit k
  logic [TEXEL_COUNT-1:0] tex_r0;
  logic [TEXEL_COUNT-1:0] tex_r1;
  logic [TEXEL_COUNT-1:0] tex_g0;
  logic [TEXEL_COUNT-1:0] tex_g1;
  logic [TEXEL_COUNT-1:0] tex_b0;
  logic [TEXEL_COUNT-1:0] tex_b1;

  assign tspi_state = i_hpos - READ_START;

  // Flash is clocked from the inverted system clock, so the outputs set up on
  // the rising clk edge are stable when the flash samples them half a cycle later
  assign o_tex_sclk = ~clk;

  // Chip select covers the whole stream, and is high after reset since hpos is 0
  assign o_tex_csb = ~(tspi_state < pos_t'(STREAM_LEN));

  // IO0 turns around once command and address are out
  assign o_tex_oeb0 = (tspi_state >= pos_t'(CMD_LEN + ADDR_LEN));

  assign data_present = (tspi_state >= pos_t'(PREAMBLE_LEN)) &&
                        (tspi_state < pos_t'(STREAM_LEN));

  // Bit selects count down so each field goes out MSB first
  assign cmd_sel   = CMD_MSB - tspi_state[2:0];
  assign slice_sel = SLICE_END - tspi_state[3:0];

  always_comb begin
    o_tex_out0 = 1'b0;
    if (tspi_state < pos_t'(CMD_LEN)) begin
      o_tex_out0 = FLASH_CMD[cmd_sel];
    end else if ((tspi_state >= pos_t'(SLICE_FIRST)) &&
                 (tspi_state <= pos_t'(SLICE_LAST))) begin
      o_tex_out0 = i_slice[slice_sel];
    end
  end

  // Nibbles shift in from the top, so after 64 of each kind byte k sits at bit k
  // IO0 carries no colour and is dropped
  always_ff @(posedge clk) begin
    if (i_rst) begin
      // Planes start black so the first line has a defined wall colour
      tex_r0 <= '0;
      tex_r1 <= '0;
      tex_g0 <= '0;
      tex_g1 <= '0;
      tex_b0 <= '0;
      tex_b1 <= '0;
    end else if (data_present) begin
      if (!tspi_state[0]) begin
        // Even state carries the low bit of each channel
        tex_r0 <= {i_tex_in[1], tex_r0[TEXEL_COUNT-1:1]};
        tex_g0 <= {i_tex_in[2], tex_g0[TEXEL_COUNT-1:1]};
        tex_b0 <= {i_tex_in[3], tex_b0[TEXEL_COUNT-1:1]};
      end else begin
        tex_r1 <= {i_tex_in[1], tex_r1[TEXEL_COUNT-1:1]};
        tex_g1 <= {i_tex_in[2], tex_g1[TEXEL_COUNT-1:1]};
        tex_b1 <= {i_tex_in[3], tex_b1[TEXEL_COUNT-1:1]};
      end
    end
  end

  // Texel lookup for the shader, blue in the high bits like a pixel
  assign o_texel = {tex_b1[i_texel_idx], tex_b0[i_texel_idx],
                    tex_g1[i_texel_idx], tex_g0[i_texel_idx],
                    tex_r1[i_texel_idx], tex_r0[i_texel_idx]};

endmodule

`default_nettype wire

// File: src/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
  import raycast_pkg::*;
#(
  parameter int H_VIEW  = 640,
  parameter int H_TOTAL = 800,
  parameter int V_VIEW  = 480,
  parameter int V_TOTAL = 525
) (
  input  logic clk,
  input  logic i_rst,
  output pos_t o_hpos,
  output pos_t o_vpos,
  output logic o_hsync,
  output logic o_vsync,
  output logic o_visible,
  output logic o_hmax,
  output logic o_frame_end
);

  // Window edges, all in counter units
  localparam pos_t H_LAST       = pos_t'(H_TOTAL - 1);
  localparam pos_t V_LAST       = pos_t'(V_TOTAL - 1);
  localparam pos_t V_VIEW_LAST  = pos_t'(V_VIEW - 1);
  localparam pos_t HSYNC_START  = pos_t'(H_VIEW + H_FRONT);
  localparam pos_t HSYNC_END    = pos_t'(H_VIEW + H_FRONT + H_SYNC);
  localparam pos_t VSYNC_START  = pos_t'(V_VIEW + V_FRONT);
  localparam pos_t VSYNC_END    = pos_t'(V_VIEW + V_FRONT + V_SYNC);

  logic vmax;

  // Pixel counter wraps every line, line counter steps once per wrap
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else if (o_hmax) begin
      o_hpos <= '0;
      o_vpos <= vmax ? '0 : o_vpos + pos_t'(1);
    end else begin
      o_hpos <= o_hpos + pos_t'(1);
    end
  end

  assign o_hmax = (o_hpos == H_LAST);
  assign vmax   = (o_vpos == V_LAST);

  // Sync pulses sit after the front porch
  assign o_hsync = (o_hpos >= HSYNC_START) && (o_hpos < HSYNC_END);
  assign o_vsync = (o_vpos >= VSYNC_START) && (o_vpos < VSYNC_END);

  assign o_visible = (o_hpos < pos_t'(H_VIEW)) && (o_vpos < pos_t'(V_VIEW));

  // Last pixel of the last visible line, where new register values take effect
  assign o_frame_end = o_hmax && (o_vpos == V_VIEW_LAST);

endmodule

`default_nettype wire

// File: verification/tb_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_model
  import tex_flash_pkg::*;
(
  input  logic       i_sclk,
  input  logic       i_csb,
  input  logic       i_io0,
  output logic [3:0] o_io
);

  // Flash clock cycles since chip select went low
  int          bit_cnt = 0;
  // Command in the top byte, then the 24 address bits
  logic [31:0] cmd_addr = '0;
  logic [3:0]  io_q = 4'h0;

  assign o_io = io_q;

  // Byte k of a slice is the low byte of slice*7 + k*13, high nibble goes out first
  function automatic logic [3:0] data_nibble(input logic [8:0] slice, input int n);
    logic [7:0] b;
    b = 8'(int'(slice) * 7 + (n / 2) * 13);
    return ((n % 2) == 1) ? b[3:0] : b[7:4];
  endfunction

  // Flash samples IO0 and moves its data on the rising flash clock
  always @(posedge i_sclk) begin
    if (i_csb) begin
      bit_cnt <= 0;
      io_q    <= 4'h0;
    end else begin
      if (bit_cnt < CMD_LEN + ADDR_LEN) begin
        cmd_addr <= {cmd_addr[30:0], i_io0};
      end
      // Data follows the dummy cycles, only for the quad read command
      if ((bit_cnt >= PREAMBLE_LEN) && (bit_cnt < STREAM_LEN) &&
          (cmd_addr[31:24] == FLASH_CMD)) begin
        io_q <= data_nibble(cmd_addr[14:6], bit_cnt - PREAMBLE_LEN);
      end else begin
        io_q <= 4'h0;
      end
      bit_cnt <= bit_cnt + 1;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_raycast_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_raycast_top
  import raycast_pkg::*, tex_flash_pkg::*;
();

  localparam int H_VIEW       = 160;
  localparam int H_TOTAL      = 320;
  localparam int V_VIEW       = 8;
  localparam int V_TOTAL      = 24;
  localparam int HALF         = H_VIEW / 2;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // Stream state 0 sits one preamble before the end of the visible line
  localparam int READ_START   = H_VIEW - PREAMBLE_LEN;
  // Slice bit 8 is flash address bit 14, sent right after the command
  localparam int SLICE_STATE  = CMD_LEN + ADDR_LEN - 1 - 14;
  // Half an SPI clock in system clocks, well above the synchroniser needs
  localparam int SCLK_HALF    = 5;

  logic       clk;
  logic       rst;
  logic       reg_ss_n;
  logic       reg_sclk;
  logic       reg_mosi;
  logic [3:0] tex_in;
  logic       tex_csb;
  logic       tex_sclk;
  logic       tex_out0;
  logic       tex_oeb0;
  logic       hsync_n;
  logic       vsync_n;
  rgb_t       rgb;
  logic       hblank;
  logic       vblank;
  pos_t       hpos;
  pos_t       vpos;

  integer seed;
  // Reference raster position and register bank, indexed by register address
  int   ref_h;
  int   ref_v;
  int   sh_reg [16];
  int   cm_reg [16];
  int   wall_checks = 0;
  logic exp_hsync_n;
  logic exp_vsync_n;

  raycast_top #(
    .H_VIEW  (H_VIEW),
    .H_TOTAL (H_TOTAL),
    .V_VIEW  (V_VIEW),
    .V_TOTAL (V_TOTAL)
  ) DUT (
    .clk        (clk),
    .i_rst      (rst),
    .i_reg_ss_n (reg_ss_n),
    .i_reg_sclk (reg_sclk),
    .i_reg_mosi (reg_mosi),
    .i_tex_in   (tex_in),
    .o_tex_csb  (tex_csb),
    .o_tex_sclk (tex_sclk),
    .o_tex_out0 (tex_out0),
    .o_tex_oeb0 (tex_oeb0),
    .o_hsync_n  (hsync_n),
    .o_vsync_n  (vsync_n),
    .o_rgb      (rgb),
    .o_hblank   (hblank),
    .o_vblank   (vblank),
    .o_hpos     (hpos),
    .o_vpos     (vpos)
  );

  tb_flash_model flash (
    .i_sclk (tex_sclk),
    .i_csb  (tex_csb),
    .i_io0  (tex_out0),
    .o_io   (tex_in)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp)
      else stop_with_error($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
  endtask

  // Byte k of a slice as the flash holds it
  function automatic int byte_of(input int slice, input int k);
    return (slice * 7 + k * 13) % 256;
  endfunction

  // High nibble arrives on an even state and carries the colour LSBs on IO1 to IO3
  function automatic int texel_of(input int b);
    logic [7:0] v;
    logic [5:0] t;
    v = 8'(b);
    t = {v[3], v[7], v[2], v[6], v[1], v[5]};
    return int'(t);
  endfunction

  // Raster reference, registers are committed on the last pixel of the last visible line
  always @(posedge clk) begin
    if (rst || ((ref_h == H_TOTAL - 1) && (ref_v == V_VIEW - 1))) begin
      cm_reg <= sh_reg;
    end
    if (rst) begin
      ref_h <= 0;
      ref_v <= 0;
    end else if (ref_h == H_TOTAL - 1) begin
      ref_h <= 0;
      ref_v <= (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
    end else begin
      ref_h <= ref_h + 1;
    end
  end

  assign exp_hsync_n = !((ref_h >= H_VIEW + H_FRONT) && (ref_h < H_VIEW + H_FRONT + H_SYNC));
  assign exp_vsync_n = !((ref_v >= V_VIEW + V_FRONT) && (ref_v < V_VIEW + V_FRONT + V_SYNC));

  assert property (@(negedge clk) disable iff (rst) hsync_n == exp_hsync_n)
    else stop_with_error($sformatf("Error at %0t ns: o_hsync_n is %b, expected %b",
                                   $time, hsync_n, exp_hsync_n));
  assert property (@(negedge clk) disable iff (rst) vsync_n == exp_vsync_n)
    else stop_with_error($sformatf("Error at %0t ns: o_vsync_n is %b, expected %b",
                                   $time, vsync_n, exp_vsync_n));
  assert property (@(negedge clk) disable iff (rst) hblank == (ref_h >= H_VIEW))
    else stop_with_error($sformatf("Error at %0t ns: o_hblank is %b, expected %b",
                                   $time, hblank, ref_h >= H_VIEW));
  assert property (@(negedge clk) disable iff (rst) vblank == (ref_v >= V_VIEW))
    else stop_with_error($sformatf("Error at %0t ns: o_vblank is %b, expected %b",
                                   $time, vblank, ref_v >= V_VIEW));
  assert property (@(negedge clk) disable iff (rst)
                   !((ref_h >= H_VIEW) || (ref_v >= V_VIEW)) || (rgb == '0))
    else stop_with_error($sformatf("Error at %0t ns: o_rgb is 0x%0h, expected 0x0",
                                   $time, rgb));

  // Outputs are combinational from the counters, so mid-cycle they are settled
  always @(negedge clk) begin
    int st;
    int exp_out0;
    int wh;
    int k;
    int idx;
    if (!rst) begin
      check_value("o_hpos", int'(hpos), ref_h);
      check_value("o_vpos", int'(vpos), ref_v);
      st = (ref_h - READ_START + 1024) % 1024;
      exp_out0 = 0;
      if (st < CMD_LEN) begin
        exp_out0 = (int'(FLASH_CMD) >> (CMD_LEN - 1 - st)) & 1;
      end else if ((st >= SLICE_STATE) && (st < SLICE_STATE + 9)) begin
        exp_out0 = (cm_reg[REG_SLICE] >> (SLICE_STATE + 8 - st)) & 1;
      end
      check_value("o_tex_csb", int'(tex_csb), int'(st >= STREAM_LEN));
      check_value("o_tex_out0", int'(tex_out0), exp_out0);
      check_value("o_tex_oeb0", int'(tex_oeb0), int'(st >= CMD_LEN + ADDR_LEN));
      if ((ref_h < H_VIEW) && (ref_v < V_VIEW)) begin
        wh = cm_reg[REG_WALL_HALF];
        if ((ref_h + wh >= HALF) && (ref_h < HALF + wh)) begin
          // Line 0 shows texels fetched in the blanking, checked from line 1
          if (ref_v >= 1) begin
            k = ref_h - ((wh > HALF) ? 0 : HALF - wh);
            idx = ((k * cm_reg[REG_TEX_STEP]) >> 8) % TEXEL_COUNT;
            check_value("o_rgb", int'(rgb), texel_of(byte_of(cm_reg[REG_SLICE], idx)));
            wall_checks++;
          end
        end else if (ref_h < HALF) begin
          check_value("o_rgb", int'(rgb), cm_reg[REG_FLOOR]);
        end else begin
          check_value("o_rgb", int'(rgb), cm_reg[REG_SKY]);
        end
      end
    end
  end

  task automatic wait_for_pos(input int line, input int pixel);
    int n;
    n = 0;
    while ((ref_v != line) || (ref_h != pixel)) begin
      @(negedge clk);
      n++;
      if (n > FRAME_CYCLES) begin
        stop_with_error("Timed out waiting for a raster position");
      end
    end
  endtask

  task automatic next_frame();
    wait_for_pos(V_VIEW, 0);
    wait_for_pos(0, 0);
  endtask

  // Sends the top nbits of a frame MSB first, mosi changes while sclk is low
  task automatic spi_frame(input logic [15:0] bits, input int nbits);
    logic [15:0] sr;
    int i;
    sr = bits;
    @(posedge clk);
    reg_ss_n <= 1'b0;
    for (i = 0; i < nbits; i++) begin
      repeat (SCLK_HALF) @(posedge clk);
      reg_sclk <= 1'b0;
      reg_mosi <= sr[15];
      sr = sr << 1;
      repeat (SCLK_HALF) @(posedge clk);
      reg_sclk <= 1'b1;
    end
    repeat (SCLK_HALF) @(posedge clk);
    reg_sclk <= 1'b0;
    reg_ss_n <= 1'b1;
    repeat (2 * SCLK_HALF) @(posedge clk);
  endtask

  task automatic write_reg(input reg_addr_t addr, input int data);
    spi_frame({addr, 12'(data)}, REG_FRAME_BITS);
    sh_reg[addr] = data;
  endtask

  initial begin
    logic [31:0] r;
    logic [5:0]  sky_now;
    logic [5:0]  floor_now;
    int round;
    seed = 32'h68bd;
    rst = 1'b1;
    reg_ss_n = 1'b1;
    reg_sclk = 1'b0;
    reg_mosi = 1'b0;
    sh_reg = '{default: 0};
    sh_reg[REG_SKY] = int'(SKY_RESET);
    sh_reg[REG_FLOOR] = int'(FLOOR_RESET);
    sh_reg[REG_WALL_HALF] = int'(WALL_HALF_RESET);
    sh_reg[REG_TEX_STEP] = int'(TEX_STEP_RESET);
    sh_reg[REG_SLICE] = int'(SLICE_RESET);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // First frame shows only the reset floor and sky
    next_frame();
    // Writes land early in a frame, so the old colours hold until its end
    // Each new colour differs from its reset value at least in bit 0
    r = $random(seed);
    write_reg(REG_SKY, int'(SKY_RESET ^ (r[5:0] | 6'h01)));
    write_reg(REG_FLOOR, int'(FLOOR_RESET ^ (r[13:8] | 6'h01)));
    next_frame();
    next_frame();
    for (round = 0; round < 2; round++) begin
      r = $random(seed);
      write_reg(REG_SLICE, int'(r[8:0]));
      write_reg(REG_WALL_HALF, int'(r[15:9]) % 100 + 1);
      write_reg(REG_TEX_STEP, int'(r[27:16]));
      next_frame();
      next_frame();
    end
    // An unknown address and a short frame must leave every register alone
    r = $random(seed);
    sky_now = 6'(sh_reg[REG_SKY]);
    floor_now = 6'(sh_reg[REG_FLOOR]);
    // Address 9 shares its low bits with the floor, and the data would change it
    spi_frame({4'd9, r[5:0], ~floor_now[5:1], 1'b0}, REG_FRAME_BITS);
    // The trailing zero above leads the short frame, so read one bit early
    // it would be a sky write of the inverted colour
    spi_frame({3'b000, 6'h00, ~sky_now, 1'b0}, REG_FRAME_BITS - 1);
    next_frame();
    next_frame();
    if (wall_checks == 0) begin
      stop_with_error("No wall pixel was reached during the run");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
src/raycast_pkg.sv
src/tex_flash_pkg.sv
src/vga_timing.sv
src/tex_flash_reader.sv
src/reg_spi_bank.sv
src/row_shader.sv
src/raycast_top.sv
verification/tb_flash_model.sv
verification/tb_raycast_top.sv
